// File: Makefile
TOP := tb_postprocessor

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f src.f --top-module $(TOP) -o $(TOP)

# pass only when the simulation prints the pass line
run: build
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module postprocessor

clean:
	rm -rf obj_dir

// File: dv/tb_clkgen.sv
module tb_clkgen (
    output logic clk_o,
    output logic rstn_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // 100 ns period
    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // reset held for 10 cycles
    initial begin
        rstn_o = 1'b0;
        repeat (10) @(posedge clk_o);
        #1 rstn_o = 1'b1;
    end

endmodule

// File: dv/tb_postprocessor.sv
module tb_postprocessor
    import pp_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic clk;
    logic rstn;
    logic [W_SIZE-1:0] q_width;
    logic [W_CHANNEL-1:0] q_channel_out;
    logic q_load_bias;
    logic q_load_scale;
    logic c_ctrl_csync_run;
    logic [W_CHANNEL-1:0] c_ctrl_chn_out;
    logic [AFFINE_DW-1:0] read_data;
    logic read_data_vld;
    psum_vec_t pe_data;
    logic pe_vld;
    logic [W_SIZE-1:0] pe_row;
    logic [W_SIZE-1:0] pe_col;
    logic [W_CHANNEL-1:0] pe_chn_out;
    logic pe_first;
    logic pe_last;
    logic o_pp_load_done;
    logic o_pp_data_vld;
    logic [TOUT*OUT_DW-1:0] o_pp_data;
    logic [OFM_AW-1:0] o_pp_addr;

    // reference model state
    logic [31:0] bias_mem [512];
    logic [31:0] scale_mem [512];
    logic [31:0] load_buf [16];
    logic [31:0] cur_bias [TOUT];
    logic [3:0] cur_shift [TOUT];
    logic signed [31:0] psum_model [256][TOUT];
    logic [31:0] exp_data [$];
    logic [15:0] exp_addr [$];
    int exp_cyc [$];
    int cfg_width;
    int cfg_chn;
    logic [31:0] rng_state = 32'h2863;

    // test and monitor counters
    int errors;
    int checks;
    int mon_errors;
    int mon_checks;
    int mon_idx;
    int done_count;
    int cyc;
    logic [31:0] last_data;

    tb_clkgen u_clkgen (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    postprocessor DUT (
        .clk                (clk),
        .rstn               (rstn),
        .q_width_i          (q_width),
        .q_channel_out_i    (q_channel_out),
        .q_load_bias_i      (q_load_bias),
        .q_load_scale_i     (q_load_scale),
        .c_ctrl_csync_run_i (c_ctrl_csync_run),
        .c_ctrl_chn_out_i   (c_ctrl_chn_out),
        .read_data_i        (read_data),
        .read_data_vld_i    (read_data_vld),
        .pe_data_i          (pe_data),
        .pe_vld_i           (pe_vld),
        .pe_row_i           (pe_row),
        .pe_col_i           (pe_col),
        .pe_chn_out_i       (pe_chn_out),
        .pe_is_first_chn_i  (pe_first),
        .pe_is_last_chn_i   (pe_last),
        .o_pp_load_done     (o_pp_load_done),
        .o_pp_data_vld      (o_pp_data_vld),
        .o_pp_data          (o_pp_data),
        .o_pp_addr          (o_pp_addr)
    );

    // ==================================================
    // model functions
    // ==================================================
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // scale 2^(k-1) gives shift k, anything else 0
    function automatic logic [3:0] shift_of(input logic [31:0] scale);
        logic [3:0] sh;
        sh = 4'd0;
        for (int k = 1; k <= 8; k++) begin
            if (scale[7:0] == 8'(1 << (k - 1))) begin
                sh = 4'(k);
            end
        end
        return sh;
    endfunction

    function automatic logic [7:0] post_lane(input logic signed [31:0] sum,
                                             input logic [3:0] sh);
        logic signed [31:0] v;
        v = (sum < 0) ? 32'sd0 : sum;
        v = v >>> sh;
        return (v > 255) ? 8'hff : v[7:0];
    endfunction

    function automatic logic [15:0] ofm_addr(input int row, input int col, input int chn);
        int a;
        a = (row * cfg_width + col) * cfg_chn + chn;
        return 16'(a);
    endfunction

    function automatic int total_errors();
        return errors + mon_errors;
    endfunction

    // ==================================================
    // cycle count and output monitor
    // ==================================================
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    always @(negedge clk) begin
        if (rstn) begin
            if (o_pp_load_done) begin
                done_count++;
            end
            if (o_pp_data_vld) begin
                last_data = o_pp_data;
                if (mon_idx >= exp_data.size()) begin
                    mon_errors++;
                    $display("FAIL %0t: unexpected output %h at address %0d",
                             $time, o_pp_data, o_pp_addr);
                end else begin
                    mon_checks++;
                    if (o_pp_data !== exp_data[mon_idx] || o_pp_addr !== exp_addr[mon_idx]
                        || cyc != exp_cyc[mon_idx]) begin
                        mon_errors++;
                        $display("FAIL %0t: got %h @%0d cycle %0d, expected %h @%0d cycle %0d",
                                 $time, o_pp_data, o_pp_addr, cyc, exp_data[mon_idx],
                                 exp_addr[mon_idx], exp_cyc[mon_idx]);
                    end
                    mon_idx++;
                end
            end
        end
    end

    // ==================================================
    // driver tasks
    // ==================================================
    task automatic set_config(input int width, input int chn);
        @(posedge clk);
        #1;
        cfg_width = width;
        cfg_chn = chn;
        q_width = 8'(width);
        q_channel_out = 7'(chn);
    endtask

    // streams load_buf with random gaps in the valid
    task automatic load_words(input logic is_scale, input int n);
        int i;
        @(posedge clk);
        #1;
        q_load_bias = ~is_scale;
        q_load_scale = is_scale;
        @(posedge clk);
        #1;
        q_load_bias = 1'b0;
        q_load_scale = 1'b0;
        i = 0;
        while (i < n) begin
            if (next_rand() % 3 == 0) begin
                read_data_vld = 1'b0;
            end else begin
                read_data = load_buf[i];
                read_data_vld = 1'b1;
                if (is_scale) begin
                    scale_mem[i] = load_buf[i];
                end else begin
                    bias_mem[i] = load_buf[i];
                end
                i++;
            end
            @(posedge clk);
            #1;
        end
        read_data_vld = 1'b0;
    endtask

    task automatic fetch_tile(input int tile);
        @(posedge clk);
        #1;
        c_ctrl_csync_run = 1'b1;
        c_ctrl_chn_out = 7'(tile);
        repeat (10) @(posedge clk);
        #1;
        c_ctrl_csync_run = 1'b0;
        for (int l = 0; l < TOUT; l++) begin
            cur_bias[l] = bias_mem[tile * TOUT + l];
            cur_shift[l] = shift_of(scale_mem[tile * TOUT + l]);
        end
    endtask

    // one PE beat, then one idle cycle
    task automatic send_beat(input int row, input int col, input int chn,
                             input logic first, input logic last, input psum_vec_t data);
        logic signed [31:0] acc;
        logic [31:0] word;
        @(posedge clk);
        #1;
        pe_data = data;
        pe_vld = 1'b1;
        pe_row = 8'(row);
        pe_col = 8'(col);
        pe_chn_out = 7'(chn);
        pe_first = first;
        pe_last = last;
        word = '0;
        for (int l = 0; l < TOUT; l++) begin
            if (first) begin
                acc = $signed(cur_bias[l]) + $signed(data[l]);
            end else begin
                acc = psum_model[col][l] + $signed(data[l]);
            end
            if (last) begin
                word[l*8 +: 8] = post_lane(acc, cur_shift[l]);
            end else begin
                psum_model[col][l] = acc;
            end
        end
        if (last) begin
            exp_data.push_back(word);
            exp_addr.push_back(ofm_addr(row, col, chn));
            exp_cyc.push_back(cyc + 4);
        end
        @(posedge clk);
        #1;
        pe_vld = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (mon_idx < exp_data.size() && n < 200) begin
            @(posedge clk);
            n++;
        end
        if (mon_idx < exp_data.size()) begin
            errors++;
            $display("timeout: %0d expected output words never appeared",
                     exp_data.size() - mon_idx);
        end
        repeat (4) @(posedge clk);
    endtask

    task automatic report(input string name, input int start_err);
        if (total_errors() == start_err) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: fail, %0d errors", name, total_errors() - start_err);
        end
    endtask

    // ==================================================
    // tests
    // ==================================================
    task automatic test_load();
        int start_err;
        int base;
        int n;
        start_err = total_errors();
        set_config(16, 2);
        base = done_count;
        for (int i = 0; i < 8; i++) begin
            load_buf[i] = 32'(i * 40 - 120);
        end
        load_words(1'b0, 8);
        repeat (20) @(posedge clk);
        checks++;
        if (done_count != base) begin
            errors++;
            $display("FAIL %0t: load done pulsed after a bias load", $time);
        end
        for (int i = 0; i < 8; i++) begin
            load_buf[i] = 32'(1 << (i % 4));
        end
        load_words(1'b1, 8);
        n = 0;
        while (done_count == base && n < 200) begin
            @(posedge clk);
            n++;
        end
        if (done_count == base) begin
            errors++;
            $display("timeout: load done never pulsed after the scale load");
        end
        repeat (20) @(posedge clk);
        checks++;
        if (done_count != base + 1) begin
            errors++;
            $display("FAIL %0t: load done pulsed %0d times", $time, done_count - base);
        end
        report("load", start_err);
    endtask

    task automatic test_single();
        int start_err;
        psum_vec_t d;
        start_err = total_errors();
        fetch_tile(1);
        for (int c = 0; c < 4; c++) begin
            for (int l = 0; l < TOUT; l++) begin
                d[l] = 32'(10 * c + 7 * l);
            end
            send_beat(2, c, 1, 1'b1, 1'b1, d);
        end
        wait_drain();
        report("single_pass", start_err);
    endtask

    task automatic test_accum();
        int start_err;
        psum_vec_t d;
        start_err = total_errors();
        fetch_tile(0);
        for (int t = 0; t < 3; t++) begin
            for (int c = 0; c < 4; c++) begin
                for (int l = 0; l < TOUT; l++) begin
                    d[l] = 32'(30 * t + 5 * c + 11 * l - 20);
                end
                send_beat(5, c + 3, 0, t == 0, t == 2, d);
            end
        end
        wait_drain();
        report("accumulate", start_err);
    endtask

    task automatic test_edges();
        int start_err;
        psum_vec_t d;
        logic [31:0] words [8];
        start_err = total_errors();
        words = '{32'hffff_fc18, 32'd0, 32'd0, 32'd7, 32'd0, 32'd0, 32'd0, 32'd0};
        for (int i = 0; i < 8; i++) begin
            load_buf[i] = words[i];
        end
        load_words(1'b0, 8);
        // 0x100 and 0x104 only count by their low byte
        words = '{32'd3, 32'h100, 32'd7, 32'h104, 32'd1, 32'd1, 32'd1, 32'd1};
        for (int i = 0; i < 8; i++) begin
            load_buf[i] = words[i];
        end
        load_words(1'b1, 8);
        fetch_tile(0);
        d = {32'd64, 32'd200, 32'd100000, 32'd10};
        send_beat(1, 9, 0, 1'b1, 1'b1, d);
        wait_drain();
        checks++;
        if (last_data !== 32'h08c8_ff00) begin
            errors++;
            $display("FAIL %0t: edge word %h, expected 08c8ff00", $time, last_data);
        end
        d = {32'd2047, 32'd255, 32'hffff_ffff, 32'hffff_ec78};
        send_beat(1, 10, 0, 1'b1, 1'b1, d);
        wait_drain();
        checks++;
        if (last_data !== 32'hffff_0000) begin
            errors++;
            $display("FAIL %0t: edge word %h, expected ffff0000", $time, last_data);
        end
        report("edge_values", start_err);
    endtask

    task automatic test_random();
        int start_err;
        int tile;
        int n_ict;
        int row;
        int base;
        psum_vec_t d;
        start_err = total_errors();
        set_config(20, 4);
        for (int i = 0; i < 16; i++) begin
            load_buf[i] = 32'(int'(next_rand() % 401) - 200);
        end
        load_words(1'b0, 16);
        for (int i = 0; i < 16; i++) begin
            load_buf[i] = 32'(1 << (next_rand() % 8));
        end
        load_words(1'b1, 16);
        for (int r = 0; r < 4; r++) begin
            tile = int'(next_rand() % 4);
            n_ict = 1 + int'(next_rand() % 3);
            row = int'(next_rand() % 20);
            base = int'(next_rand() % 256);
            fetch_tile(tile);
            for (int t = 0; t < n_ict; t++) begin
                for (int c = 0; c < 4; c++) begin
                    for (int l = 0; l < TOUT; l++) begin
                        d[l] = 32'(int'(next_rand() % 1200) - 300);
                    end
                    send_beat(row, (base + 3 * c) % 256, tile, t == 0, t == n_ict - 1, d);
                end
            end
            wait_drain();
        end
        report("random", start_err);
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        int n;
        q_width = '0;
        q_channel_out = '0;
        q_load_bias = 1'b0;
        q_load_scale = 1'b0;
        c_ctrl_csync_run = 1'b0;
        c_ctrl_chn_out = '0;
        read_data = '0;
        read_data_vld = 1'b0;
        pe_data = '0;
        pe_vld = 1'b0;
        pe_row = '0;
        pe_col = '0;
        pe_chn_out = '0;
        pe_first = 1'b0;
        pe_last = 1'b0;
        n = 0;
        while (!rstn && n < 200) begin
            @(posedge clk);
            n++;
        end
        if (!rstn) begin
            errors++;
            $display("timeout: reset was never released");
        end
        test_load();
        test_single();
        test_accum();
        test_edges();
        test_random();
        $display("checks %0d, errors %0d", checks + mon_checks, total_errors());
        if (total_errors() == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: rtl/affine_fetch.sv
module affine_fetch
    import pp_pkg::*;
(
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 csync_run_i,
    input  logic                 tail_vld_i,
    input  logic [W_CHANNEL-1:0] chn_out_i,
    output logic                 rd_en_o,
    output logic [AFFINE_AW-1:0] rd_addr_o,
    input  logic [AFFINE_DW-1:0] bias_data_i,
    input  logic [AFFINE_DW-1:0] scale_data_i,
    output affine_t              affine_o
);

    fetch_state_e         state_q;
    logic                 sync_ok;
    logic                 sync_ok_d;
    logic                 start;
    logic [AFFINE_AW-1:0] addr_q;
    logic [TOUT_W-1:0]    rd_lane_q;
    logic                 fill_vld_q;
    logic [TOUT_W-1:0]    fill_lane_q;
    affine_t              affine_q;

    // power-of-two scale to right-shift amount
    function automatic logic [SHIFT_W-1:0] scale2shift(input logic [7:0] scale);
        logic [SHIFT_W-1:0] shift;
        case (scale)
            8'h01:   shift = 4'd1;
            8'h02:   shift = 4'd2;
            8'h04:   shift = 4'd3;
            8'h08:   shift = 4'd4;
            8'h10:   shift = 4'd5;
            8'h20:   shift = 4'd6;
            8'h40:   shift = 4'd7;
            8'h80:   shift = 4'd8;
            default: shift = 4'd0;
        endcase
        return shift;
    endfunction

    // wait for the accumulator tail to drain before switching tiles
    assign sync_ok = csync_run_i & ~tail_vld_i;
    assign start   = sync_ok & ~sync_ok_d;

    // ==================================================
    // read sequencer
    // ==================================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sync_ok_d   <= 1'b0;
            state_q     <= FETCH_IDLE;
            addr_q      <= '0;
            rd_lane_q   <= '0;
            fill_vld_q  <= 1'b0;
            fill_lane_q <= '0;
        end else begin
            sync_ok_d   <= sync_ok;
            fill_vld_q  <= (state_q == FETCH_READ);
            fill_lane_q <= rd_lane_q;
            case (state_q)
                FETCH_IDLE: begin
                    if (start) begin
                        state_q   <= FETCH_READ;
                        addr_q    <= AFFINE_AW'(chn_out_i) * AFFINE_AW'(TOUT);
                        rd_lane_q <= '0;
                    end
                end
                FETCH_READ: begin
                    addr_q    <= addr_q + 1'b1;
                    rd_lane_q <= rd_lane_q + 1'b1;
                    if (rd_lane_q == TOUT_W'(TOUT - 1)) begin
                        state_q <= FETCH_IDLE;
                    end
                end
                default: state_q <= FETCH_IDLE;
            endcase
        end
    end

    assign rd_en_o   = (state_q == FETCH_READ);
    assign rd_addr_o = addr_q;

    // lane registers, filled one cycle after each read
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            affine_q <= '0;
        end else if (fill_vld_q) begin
            affine_q.bias[fill_lane_q]  <= bias_data_i;
            affine_q.shift[fill_lane_q] <= scale2shift(scale_data_i[7:0]);
        end
    end

    assign affine_o = affine_q;

endmodule

// File: rtl/affine_loader.sv
module affine_loader
    import pp_pkg::*;
(
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 q_load_bias_i,
    input  logic                 q_load_scale_i,
    input  logic [W_CHANNEL-1:0] q_channel_out_i,
    input  logic [AFFINE_DW-1:0] read_data_i,
    input  logic                 read_data_vld_i,
    output logic                 bias_wr_en_o,
    output logic                 scale_wr_en_o,
    output logic [AFFINE_AW-1:0] wr_addr_o,
    output logic [AFFINE_DW-1:0] wr_data_o,
    output logic                 load_done_o
);

    load_state_e          state_q;
    logic                 load_bias_d;
    logic                 load_scale_d;
    logic                 bias_start;
    logic                 scale_start;
    logic [AFFINE_DW-1:0] data_q;
    logic                 vld_q;
    logic [AFFINE_AW-1:0] addr_q;
    logic [AFFINE_AW-1:0] load_words;
    logic                 last_word;
    logic                 done_q;

    // request edges
    assign bias_start  = q_load_bias_i & ~load_bias_d;
    assign scale_start = q_load_scale_i & ~load_scale_d;

    // one word per lane for every output-channel tile
    assign load_words = AFFINE_AW'(q_channel_out_i) * AFFINE_AW'(TOUT);
    assign last_word  = vld_q && (addr_q == load_words - 1'b1);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            load_bias_d  <= 1'b0;
            load_scale_d <= 1'b0;
            vld_q        <= 1'b0;
        end else begin
            load_bias_d  <= q_load_bias_i;
            load_scale_d <= q_load_scale_i;
            vld_q        <= read_data_vld_i;
        end
    end

    always_ff @(posedge clk) begin
        data_q <= read_data_i;
    end

    // ==================================================
    // load FSM
    // ==================================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q <= LOAD_IDLE;
            addr_q  <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= (state_q == LOAD_SCALE) && last_word;
            case (state_q)
                LOAD_IDLE: begin
                    if (bias_start) begin
                        state_q <= LOAD_BIAS;
                        addr_q  <= '0;
                    end else if (scale_start) begin
                        state_q <= LOAD_SCALE;
                        addr_q  <= '0;
                    end
                end
                LOAD_BIAS, LOAD_SCALE: begin
                    if (vld_q) begin
                        addr_q <= addr_q + 1'b1;
                    end
                    if (last_word) begin
                        state_q <= LOAD_IDLE;
                    end
                end
                default: state_q <= LOAD_IDLE;
            endcase
        end
    end

    // steer the registered beat to the selected buffer
    assign bias_wr_en_o  = (state_q == LOAD_BIAS) && vld_q;
    assign scale_wr_en_o = (state_q == LOAD_SCALE) && vld_q;
    assign wr_addr_o     = addr_q;
    assign wr_data_o     = data_q;
    assign load_done_o   = done_q;

endmodule

// File: rtl/dual_port_ram.sv
module dual_port_ram #(
    parameter int DEPTH = 256,
    parameter int DW    = 32
) (
    input  logic                     clk,
    // write port
    input  logic                     wr_en_i,
    input  logic [$clog2(DEPTH)-1:0] wr_addr_i,
    input  logic [DW-1:0]            wr_data_i,
    // read port
    input  logic                     rd_en_i,
    input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
    output logic [DW-1:0]            rd_data_o
);

    logic [DW-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // same-address read returns the old word
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

// File: rtl/ofm_writer.sv
module ofm_writer
    import pp_pkg::*;
(
    input  logic                         clk,
    input  logic                         rstn,
    input  pe_beat_t                     final_i,
    input  logic [TOUT-1:0][SHIFT_W-1:0] shift_i,
    input  logic [W_SIZE-1:0]            q_width_i,
    input  logic [W_CHANNEL-1:0]         q_channel_out_i,
    output logic                         o_pp_data_vld,
    output logic [TOUT*OUT_DW-1:0]       o_pp_data,
    output logic [OFM_AW-1:0]            o_pp_addr
);

    psum_vec_t                    relu;
    psum_vec_t                    shifted;
    logic [TOUT-1:0][OUT_DW-1:0]  lanes_d;
    logic [OFM_AW-1:0]            pix_idx;
    logic [OFM_AW-1:0]            addr_d;

    // relu, shift, clamp to 8 bits
    always_comb begin
        for (int l = 0; l < TOUT; l++) begin
            relu[l]    = final_i.data[l][PSUM_DW-1] ? '0 : final_i.data[l];
            shifted[l] = relu[l] >> shift_i[l];
            if (|shifted[l][PSUM_DW-1:OUT_DW]) begin
                lanes_d[l] = '1;
            end else begin
                lanes_d[l] = shifted[l][OUT_DW-1:0];
            end
        end
    end

    // pixel index, then channel-tile interleave
    assign pix_idx = OFM_AW'(final_i.row) * OFM_AW'(q_width_i) + OFM_AW'(final_i.col);
    assign addr_d  = pix_idx * OFM_AW'(q_channel_out_i) + OFM_AW'(final_i.chn_out);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_pp_data_vld <= 1'b0;
        end else begin
            o_pp_data_vld <= final_i.vld;
        end
    end

    // lane 0 lands in the low byte
    always_ff @(posedge clk) begin
        if (final_i.vld) begin
            o_pp_data <= lanes_d;
            o_pp_addr <= addr_d;
        end
    end

endmodule

// File: rtl/postprocessor.sv
module postprocessor
    import pp_pkg::*;
(
    input  logic                      clk,
    input  logic                      rstn,
    // layer config
    input  logic [W_SIZE-1:0]         q_width_i,
    input  logic [W_CHANNEL-1:0]      q_channel_out_i,
    input  logic                      q_load_bias_i,
    input  logic                      q_load_scale_i,
    // controller
    input  logic                      c_ctrl_csync_run_i,
    input  logic [W_CHANNEL-1:0]      c_ctrl_chn_out_i,
    // AXI read data
    input  logic [AFFINE_DW-1:0]      read_data_i,
    input  logic                      read_data_vld_i,
    // PE engine
    input  logic [TOUT*PSUM_DW-1:0]   pe_data_i,
    input  logic                      pe_vld_i,
    input  logic [W_SIZE-1:0]         pe_row_i,
    input  logic [W_SIZE-1:0]         pe_col_i,
    input  logic [W_CHANNEL-1:0]      pe_chn_out_i,
    input  logic                      pe_is_first_chn_i,
    input  logic                      pe_is_last_chn_i,
    // outputs
    output logic                      o_pp_load_done,
    output logic                      o_pp_data_vld,
    output logic [TOUT*OUT_DW-1:0]    o_pp_data,
    output logic [OFM_AW-1:0]         o_pp_addr
);

    logic                 bias_wr_en;
    logic                 scale_wr_en;
    logic [AFFINE_AW-1:0] load_addr;
    logic [AFFINE_DW-1:0] load_data;
    logic                 fetch_rd_en;
    logic [AFFINE_AW-1:0] fetch_addr;
    logic [AFFINE_DW-1:0] bias_rd_data;
    logic [AFFINE_DW-1:0] scale_rd_data;
    affine_t              affine;
    logic                 tail_vld;
    pe_beat_t             pe_beat;
    pe_beat_t             final_beat;

    assign pe_beat = '{
        data:    pe_data_i,
        vld:     pe_vld_i,
        row:     pe_row_i,
        col:     pe_col_i,
        chn_out: pe_chn_out_i,
        first:   pe_is_first_chn_i,
        last:    pe_is_last_chn_i
    };

    // ==================================================
    // bias and scale storage
    // ==================================================
    affine_loader u_loader (
        .clk             (clk),
        .rstn            (rstn),
        .q_load_bias_i   (q_load_bias_i),
        .q_load_scale_i  (q_load_scale_i),
        .q_channel_out_i (q_channel_out_i),
        .read_data_i     (read_data_i),
        .read_data_vld_i (read_data_vld_i),
        .bias_wr_en_o    (bias_wr_en),
        .scale_wr_en_o   (scale_wr_en),
        .wr_addr_o       (load_addr),
        .wr_data_o       (load_data),
        .load_done_o     (o_pp_load_done)
    );

    dual_port_ram #(.DEPTH(1 << AFFINE_AW), .DW(AFFINE_DW)) u_bias_buf (
        .clk       (clk),
        .wr_en_i   (bias_wr_en),
        .wr_addr_i (load_addr),
        .wr_data_i (load_data),
        .rd_en_i   (fetch_rd_en),
        .rd_addr_i (fetch_addr),
        .rd_data_o (bias_rd_data)
    );

    dual_port_ram #(.DEPTH(1 << AFFINE_AW), .DW(AFFINE_DW)) u_scale_buf (
        .clk       (clk),
        .wr_en_i   (scale_wr_en),
        .wr_addr_i (load_addr),
        .wr_data_i (load_data),
        .rd_en_i   (fetch_rd_en),
        .rd_addr_i (fetch_addr),
        .rd_data_o (scale_rd_data)
    );

    affine_fetch u_fetch (
        .clk          (clk),
        .rstn         (rstn),
        .csync_run_i  (c_ctrl_csync_run_i),
        .tail_vld_i   (tail_vld),
        .chn_out_i    (c_ctrl_chn_out_i),
        .rd_en_o      (fetch_rd_en),
        .rd_addr_o    (fetch_addr),
        .bias_data_i  (bias_rd_data),
        .scale_data_i (scale_rd_data),
        .affine_o     (affine)
    );

    // ==================================================
    // accumulate and write out
    // ==================================================
    psum_accumulator u_acc (
        .clk        (clk),
        .rstn       (rstn),
        .beat_i     (pe_beat),
        .bias_i     (affine.bias),
        .tail_vld_o (tail_vld),
        .final_o    (final_beat)
    );

    ofm_writer u_writer (
        .clk             (clk),
        .rstn            (rstn),
        .final_i         (final_beat),
        .shift_i         (affine.shift),
        .q_width_i       (q_width_i),
        .q_channel_out_i (q_channel_out_i),
        .o_pp_data_vld   (o_pp_data_vld),
        .o_pp_data       (o_pp_data),
        .o_pp_addr       (o_pp_addr)
    );

endmodule

// File: rtl/pp_pkg.sv
package pp_pkg;

    // ==================================================
    // widths
    // ==================================================
    localparam int TOUT      = 4;
    localparam int TOUT_W    = 2;
    localparam int PSUM_DW   = 32;
    localparam int OUT_DW    = 8;
    localparam int W_SIZE    = 8;
    localparam int W_CHANNEL = 7;
    localparam int AFFINE_AW = 9;
    localparam int AFFINE_DW = 32;
    localparam int PSUM_AW   = 8;
    localparam int OFM_AW    = 16;
    localparam int SHIFT_W   = 4;

    // ==================================================
    // types
    // ==================================================
    // one partial sum per output-channel lane
    typedef logic [TOUT-1:0][PSUM_DW-1:0] psum_vec_t;

    // one PE result with its position in the feature map
    typedef struct packed {
        psum_vec_t              data;
        logic                   vld;
        logic [W_SIZE-1:0]      row;
        logic [W_SIZE-1:0]      col;
        logic [W_CHANNEL-1:0]   chn_out;
        logic                   first;
        logic                   last;
    } pe_beat_t;

    // per-tile bias and shift, one entry per lane
    typedef struct packed {
        logic [TOUT-1:0][AFFINE_DW-1:0] bias;
        logic [TOUT-1:0][SHIFT_W-1:0]   shift;
    } affine_t;

    typedef enum logic [1:0] {
        LOAD_IDLE  = 2'd0,
        LOAD_BIAS  = 2'd1,
        LOAD_SCALE = 2'd2
    } load_state_e;

    typedef enum logic {
        FETCH_IDLE = 1'b0,
        FETCH_READ = 1'b1
    } fetch_state_e;

endpackage

// File: rtl/psum_accumulator.sv
module psum_accumulator
    import pp_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  pe_beat_t  beat_i,
    input  psum_vec_t bias_i,
    output logic      tail_vld_o,
    output pe_beat_t  final_o
);

    pe_beat_t  s0_q;
    pe_beat_t  s1_q;
    pe_beat_t  s2_q;
    psum_vec_t rd_psum;
    psum_vec_t addend;
    psum_vec_t sum_d;
    logic      rd_en;
    logic      wr_en;

    // ==================================================
    // row buffer, one entry per column
    // ==================================================
    dual_port_ram #(
        .DEPTH (1 << PSUM_AW),
        .DW    (TOUT * PSUM_DW)
    ) u_psum_buf (
        .clk       (clk),
        .wr_en_i   (wr_en),
        .wr_addr_i (s2_q.col),
        .wr_data_i (s2_q.data),
        .rd_en_i   (rd_en),
        .rd_addr_i (s0_q.col),
        .rd_data_o (rd_psum)
    );

    // ==================================================
    // pipeline
    // ==================================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s0_q <= '0;
            s1_q <= '0;
            s2_q <= '0;
        end else begin
            s0_q      <= beat_i;
            s1_q      <= s0_q;
            s2_q      <= s1_q;
            s2_q.data <= sum_d;
        end
    end

    // stage 0: fetch stored sum, the first tile starts from bias
    assign rd_en = s0_q.vld & ~s0_q.first;

    // stage 1: signed add per lane
    always_comb begin
        for (int l = 0; l < TOUT; l++) begin
            addend[l] = s1_q.first ? bias_i[l] : rd_psum[l];
            sum_d[l]  = $signed(s1_q.data[l]) + $signed(addend[l]);
        end
    end

    // stage 2: keep running sums, pass on the final ones
    assign wr_en = s2_q.vld & ~s2_q.last;

    always_comb begin
        final_o     = s2_q;
        final_o.vld = s2_q.vld & s2_q.last;
    end

    assign tail_vld_o = s2_q.vld;

endmodule

// File: src.f
rtl/pp_pkg.sv
rtl/dual_port_ram.sv
rtl/affine_loader.sv
rtl/affine_fetch.sv
rtl/psum_accumulator.sv
rtl/ofm_writer.sv
rtl/postprocessor.sv
dv/tb_clkgen.sv
dv/tb_postprocessor.sv
